// ==== logic/gpu_mem_pkg.sv ====
`default_nettype none

package gpu_mem_pkg;

	// Line geometry
	localparam int LANES      = 8;
	localparam int LANE_W     = 32;
	localparam int LINE_W     = LANES * LANE_W;
	localparam int BANK_DEPTH = 512;
	localparam int BANK_AW    = 9;

	// Full address as seen by the pipeline, the low BANK_AW bits pick the line
	localparam int MEM_AW = 27;

	// Instruction metadata
	localparam int WARP_W = 3;
	localparam int SCB_W  = 2;
	localparam int REG_W  = 5;
	localparam int LAT_W  = 5;

	// Miss queue
	localparam int MQ_DEPTH = 8;
	localparam int MQ_AW    = 3;

	// Wishbone word address is line index followed by a three bit lane index
	localparam int WB_AW = BANK_AW + 3;

	typedef enum logic [1:0]
	{
		MOP_NONE  = 2'd0,
		MOP_LOAD  = 2'd1,
		MOP_STORE = 2'd2
	} mem_op_e;

	typedef enum logic
	{
		FILL_IDLE = 1'b0,
		FILL_ACK  = 1'b1
	} fill_state_e;

endpackage

`default_nettype wire

// ==== logic/lane_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_bank
(
	input  wire                            clk,
	input  wire                            a_we_i,
	input  wire [gpu_mem_pkg::BANK_AW-1:0] a_addr_i,
	input  wire [gpu_mem_pkg::LANE_W-1:0]  a_din_i,
	output logic [gpu_mem_pkg::LANE_W-1:0] a_dout_o,
	input  wire                            b_we_i,
	input  wire [gpu_mem_pkg::BANK_AW-1:0] b_addr_i,
	input  wire [gpu_mem_pkg::LANE_W-1:0]  b_din_i,
	output logic [gpu_mem_pkg::LANE_W-1:0] b_dout_o
);
	import gpu_mem_pkg::*;

	logic [LANE_W-1:0] mem [0:BANK_DEPTH-1];

	// Both ports read the old word when they write in the same cycle
	always_ff @(posedge clk)
	begin
		if (a_we_i)
		begin
			mem[a_addr_i] <= a_din_i;
		end
		if (b_we_i)
		begin
			mem[b_addr_i] <= b_din_i;
		end
		a_dout_o <= mem[a_addr_i];
		b_dout_o <= mem[b_addr_i];
	end

endmodule

`default_nettype wire

// ==== logic/miss_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_queue
(
	input  wire                           clk,
	input  wire                           resetb,
	input  wire                           push_i,
	input  wire [gpu_mem_pkg::MEM_AW-1:0] addr_i,
	input  wire [gpu_mem_pkg::WARP_W-1:0] warp_i,
	input  wire [gpu_mem_pkg::SCB_W-1:0]  scb_i,
	input  wire [gpu_mem_pkg::LAT_W-1:0]  lat_i,
	output logic                          full_o,
	output logic                          fb_valid_o,
	output logic [gpu_mem_pkg::MEM_AW-1:0] fb_addr_o,
	output logic [gpu_mem_pkg::WARP_W-1:0] fb_warp_o,
	output logic [gpu_mem_pkg::SCB_W-1:0]  fb_scb_o
);
	import gpu_mem_pkg::*;

	logic [MEM_AW-1:0] addr_mem [0:MQ_DEPTH-1];
	logic [WARP_W-1:0] warp_mem [0:MQ_DEPTH-1];
	logic [SCB_W-1:0]  scb_mem  [0:MQ_DEPTH-1];
	logic [LAT_W-1:0]  lat_mem  [0:MQ_DEPTH-1];

	logic [MQ_AW-1:0] wr_ptr;
	logic [MQ_AW-1:0] rd_ptr;
	logic [MQ_AW:0]   count;
	logic             head_active;
	logic [LAT_W-1:0] head_cnt;
	logic             do_push;
	logic             do_pop;

	assign full_o  = (count == (MQ_AW+1)'(MQ_DEPTH));
	assign do_push = push_i && !full_o;

	// The head leaves on the edge its countdown runs out
	assign do_pop = head_active && (head_cnt == LAT_W'(1));

	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			addr_mem[wr_ptr] <= addr_i;
			warp_mem[wr_ptr] <= warp_i;
			scb_mem[wr_ptr]  <= scb_i;
			lat_mem[wr_ptr]  <= lat_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			head_active <= 1'b0;
			head_cnt    <= '0;
			fb_valid_o  <= 1'b0;
		end
		else
		begin
			fb_valid_o <= do_pop;

			if (do_push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// A new head is loaded one cycle after the previous one leaves
			if (do_pop)
			begin
				head_active <= 1'b0;
			end
			else if (head_active)
			begin
				head_cnt <= head_cnt - 1'b1;
			end
			else if (count != '0)
			begin
				head_active <= 1'b1;
				head_cnt    <= lat_mem[rd_ptr];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_pop)
		begin
			fb_addr_o <= addr_mem[rd_ptr];
			fb_warp_o <= warp_mem[rd_ptr];
			fb_scb_o  <= scb_mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/fill_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module fill_port
(
	input  wire                                clk,
	input  wire                                resetb,
	input  wire                                wb_cyc_i,
	input  wire                                wb_stb_i,
	input  wire                                wb_we_i,
	input  wire [gpu_mem_pkg::WB_AW-1:0]       wb_adr_i,
	input  wire [gpu_mem_pkg::LANE_W-1:0]      wb_dat_i,
	output logic [gpu_mem_pkg::LANE_W-1:0]     wb_dat_o,
	output logic                               wb_ack_o,
	output logic                               fill_en_o,
	output logic                               fill_we_o,
	output logic [gpu_mem_pkg::WB_AW-gpu_mem_pkg::BANK_AW-1:0] fill_lane_o,
	output logic [gpu_mem_pkg::BANK_AW-1:0]    fill_line_o,
	output logic [gpu_mem_pkg::LANE_W-1:0]     fill_data_o,
	input  wire [gpu_mem_pkg::LINE_W-1:0]      fill_rdata_i
);
	import gpu_mem_pkg::*;

	fill_state_e                  state;
	logic [WB_AW-BANK_AW-1:0]     lane_q;
	logic                         req;

	assign req = wb_cyc_i && wb_stb_i;

	// One bank access per transfer, only when the request is first seen
	assign fill_en_o   = (state == FILL_IDLE) && req;
	assign fill_we_o   = wb_we_i;
	assign fill_line_o = wb_adr_i[WB_AW-1:WB_AW-BANK_AW];
	assign fill_lane_o = wb_adr_i[WB_AW-BANK_AW-1:0];
	assign fill_data_o = wb_dat_i;

	assign wb_ack_o = (state == FILL_ACK) && req;
	assign wb_dat_o = fill_rdata_i[lane_q*LANE_W +: LANE_W];

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			state <= FILL_IDLE;
		end
		else
		begin
			case (state)
				FILL_IDLE: if (req) state <= FILL_ACK;
				default: state <= FILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_en_o)
		begin
			lane_q <= fill_lane_o;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage
(
	input  wire                            clk,
	input  wire                            resetb,
	input  gpu_mem_pkg::mem_op_e           op_i,
	input  wire [gpu_mem_pkg::MEM_AW-1:0]  mem_addr_i,
	input  wire [gpu_mem_pkg::LINE_W-1:0]  write_data_i,
	input  wire [gpu_mem_pkg::LANES-1:0]   lane_wmask_i,
	input  wire [gpu_mem_pkg::WARP_W-1:0]  warp_id_i,
	input  wire [gpu_mem_pkg::SCB_W-1:0]   scb_id_i,
	input  wire [gpu_mem_pkg::REG_W-1:0]   reg_addr_i,
	input  wire [gpu_mem_pkg::LANES-1:0]   thread_mask_i,
	input  wire                            hit_i,
	input  wire                            addr_valid_i,
	input  wire [gpu_mem_pkg::LAT_W-1:0]   miss_latency_i,
	input  wire                            miss_wait_i,
	output logic                           reg_write_o,
	output logic                           write_fb_valid_o,
	output logic [gpu_mem_pkg::LINE_W-1:0] read_data_o,
	output logic [gpu_mem_pkg::WARP_W-1:0] warp_id_o,
	output logic [gpu_mem_pkg::SCB_W-1:0]  scb_id_o,
	output logic [gpu_mem_pkg::REG_W-1:0]  reg_addr_o,
	output logic [gpu_mem_pkg::LANES-1:0]  thread_mask_o,
	input  wire                            fill_en_i,
	input  wire                            fill_we_i,
	input  wire [gpu_mem_pkg::WB_AW-gpu_mem_pkg::BANK_AW-1:0] fill_lane_i,
	input  wire [gpu_mem_pkg::BANK_AW-1:0] fill_line_i,
	input  wire [gpu_mem_pkg::LANE_W-1:0]  fill_data_i,
	output logic [gpu_mem_pkg::LINE_W-1:0] fill_data_o,
	output logic                           mq_push_o,
	output logic [gpu_mem_pkg::MEM_AW-1:0] mq_addr_o,
	output logic [gpu_mem_pkg::WARP_W-1:0] mq_warp_o,
	output logic [gpu_mem_pkg::SCB_W-1:0]  mq_scb_o,
	output logic [gpu_mem_pkg::LAT_W-1:0]  mq_lat_o,
	input  wire                            mq_full_i
);
	import gpu_mem_pkg::*;

	logic [LINE_W-1:0] rd_line;
	logic [LANES-1:0]  fill_lane_dec;
	logic              store_w;

	mem_op_e           op_q;
	logic [WARP_W-1:0] warp_q;
	logic [SCB_W-1:0]  scb_q;
	logic [REG_W-1:0]  reg_q;
	logic [LANES-1:0]  tmask_q;

	assign store_w       = (op_i == MOP_STORE);
	assign fill_lane_dec = LANES'(1) << fill_lane_i;

	for (genvar i = 0; i < LANES; i++)
	begin : g_bank
		lane_bank u_bank
		(
			.clk      (clk),
			.a_we_i   (store_w && lane_wmask_i[i]),
			.a_addr_i (mem_addr_i[BANK_AW-1:0]),
			.a_din_i  (write_data_i[i*LANE_W +: LANE_W]),
			.a_dout_o (rd_line[i*LANE_W +: LANE_W]),
			.b_we_i   (fill_en_i && fill_we_i && fill_lane_dec[i]),
			.b_addr_i (fill_line_i),
			.b_din_i  (fill_data_i),
			.b_dout_o (fill_data_o[i*LANE_W +: LANE_W])
		);
	end

	// Misses go to the queue in the cycle they are presented
	assign mq_push_o = addr_valid_i && !hit_i && !mq_full_i;
	assign mq_addr_o = mem_addr_i;
	assign mq_warp_o = warp_id_i;
	assign mq_scb_o  = scb_id_i;

	always_comb
	begin
		if (miss_wait_i || (miss_latency_i == '0))
		begin
			mq_lat_o = LAT_W'(1);
		end
		else
		begin
			mq_lat_o = miss_latency_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			op_q             <= MOP_NONE;
			reg_write_o      <= 1'b0;
			write_fb_valid_o <= 1'b0;
			read_data_o      <= '0;
		end
		else
		begin
			op_q             <= op_i;
			reg_write_o      <= (op_q == MOP_LOAD);
			write_fb_valid_o <= (op_q == MOP_STORE);
			if (op_q == MOP_LOAD)
			begin
				read_data_o <= rd_line;
			end
			else
			begin
				read_data_o <= '0;
			end
		end
	end

	// Metadata rides alongside the opcode through both stages
	always_ff @(posedge clk)
	begin
		warp_q        <= warp_id_i;
		scb_q         <= scb_id_i;
		reg_q         <= reg_addr_i;
		tmask_q       <= thread_mask_i;
		warp_id_o     <= warp_q;
		scb_id_o      <= scb_q;
		reg_addr_o    <= reg_q;
		thread_mask_o <= tmask_q;
	end

endmodule

`default_nettype wire

// ==== logic/mem_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_unit
(
	input  wire                            clk,
	input  wire                            resetb,
	input  gpu_mem_pkg::mem_op_e           op_i,
	input  wire [gpu_mem_pkg::MEM_AW-1:0]  mem_addr_i,
	input  wire [gpu_mem_pkg::LINE_W-1:0]  write_data_i,
	input  wire [gpu_mem_pkg::LANES-1:0]   lane_wmask_i,
	input  wire [gpu_mem_pkg::WARP_W-1:0]  warp_id_i,
	input  wire [gpu_mem_pkg::SCB_W-1:0]   scb_id_i,
	input  wire [gpu_mem_pkg::REG_W-1:0]   reg_addr_i,
	input  wire [gpu_mem_pkg::LANES-1:0]   thread_mask_i,
	input  wire                            hit_i,
	input  wire                            addr_valid_i,
	input  wire [gpu_mem_pkg::LAT_W-1:0]   miss_latency_i,
	input  wire                            miss_wait_i,
	output logic                           reg_write_o,
	output logic                           write_fb_valid_o,
	output logic [gpu_mem_pkg::LINE_W-1:0] read_data_o,
	output logic [gpu_mem_pkg::WARP_W-1:0] warp_id_o,
	output logic [gpu_mem_pkg::SCB_W-1:0]  scb_id_o,
	output logic [gpu_mem_pkg::REG_W-1:0]  reg_addr_o,
	output logic [gpu_mem_pkg::LANES-1:0]  thread_mask_o,
	output logic                           fb_valid_o,
	output logic [gpu_mem_pkg::MEM_AW-1:0] fb_addr_o,
	output logic [gpu_mem_pkg::WARP_W-1:0] fb_warp_o,
	output logic [gpu_mem_pkg::SCB_W-1:0]  fb_scb_o,
	output logic                           mq_full_o,
	input  wire                            wb_cyc_i,
	input  wire                            wb_stb_i,
	input  wire                            wb_we_i,
	input  wire [gpu_mem_pkg::WB_AW-1:0]   wb_adr_i,
	input  wire [gpu_mem_pkg::LANE_W-1:0]  wb_dat_i,
	output logic [gpu_mem_pkg::LANE_W-1:0] wb_dat_o,
	output logic                           wb_ack_o
);
	import gpu_mem_pkg::*;

	logic                     fill_en;
	logic                     fill_we;
	logic [WB_AW-BANK_AW-1:0] fill_lane;
	logic [BANK_AW-1:0]       fill_line;
	logic [LANE_W-1:0]        fill_wdata;
	logic [LINE_W-1:0]        fill_rdata;

	logic                     mq_push;
	logic [MEM_AW-1:0]        mq_addr;
	logic [WARP_W-1:0]        mq_warp;
	logic [SCB_W-1:0]         mq_scb;
	logic [LAT_W-1:0]         mq_lat;

	mem_stage u_stage
	(
		.clk              (clk),
		.resetb           (resetb),
		.op_i             (op_i),
		.mem_addr_i       (mem_addr_i),
		.write_data_i     (write_data_i),
		.lane_wmask_i     (lane_wmask_i),
		.warp_id_i        (warp_id_i),
		.scb_id_i         (scb_id_i),
		.reg_addr_i       (reg_addr_i),
		.thread_mask_i    (thread_mask_i),
		.hit_i            (hit_i),
		.addr_valid_i     (addr_valid_i),
		.miss_latency_i   (miss_latency_i),
		.miss_wait_i      (miss_wait_i),
		.reg_write_o      (reg_write_o),
		.write_fb_valid_o (write_fb_valid_o),
		.read_data_o      (read_data_o),
		.warp_id_o        (warp_id_o),
		.scb_id_o         (scb_id_o),
		.reg_addr_o       (reg_addr_o),
		.thread_mask_o    (thread_mask_o),
		.fill_en_i        (fill_en),
		.fill_we_i        (fill_we),
		.fill_lane_i      (fill_lane),
		.fill_line_i      (fill_line),
		.fill_data_i      (fill_wdata),
		.fill_data_o      (fill_rdata),
		.mq_push_o        (mq_push),
		.mq_addr_o        (mq_addr),
		.mq_warp_o        (mq_warp),
		.mq_scb_o         (mq_scb),
		.mq_lat_o         (mq_lat),
		.mq_full_i        (mq_full_o)
	);

	miss_queue u_mq
	(
		.clk        (clk),
		.resetb     (resetb),
		.push_i     (mq_push),
		.addr_i     (mq_addr),
		.warp_i     (mq_warp),
		.scb_i      (mq_scb),
		.lat_i      (mq_lat),
		.full_o     (mq_full_o),
		.fb_valid_o (fb_valid_o),
		.fb_addr_o  (fb_addr_o),
		.fb_warp_o  (fb_warp_o),
		.fb_scb_o   (fb_scb_o)
	);

	fill_port u_fill
	(
		.clk          (clk),
		.resetb       (resetb),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.fill_en_o    (fill_en),
		.fill_we_o    (fill_we),
		.fill_lane_o  (fill_lane),
		.fill_line_o  (fill_line),
		.fill_data_o  (fill_wdata),
		.fill_rdata_i (fill_rdata)
	);

endmodule

`default_nettype wire

// ==== tests/mem_unit_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_unit_chk
(
	input wire clk,
	input wire resetb,
	input wire wb_cyc_i,
	input wire wb_stb_i,
	input wire wb_ack_i,
	input wire fb_valid_i,
	input wire reg_write_i,
	input wire write_fb_i
);

	// Ack answers a request that was already present on the previous cycle
	ack_under_request: assert property (@(posedge clk) disable iff (!resetb)
		wb_ack_i |-> (wb_cyc_i && wb_stb_i && $past(wb_cyc_i && wb_stb_i)))
		else $error("Wishbone ack seen without a request held since the previous cycle");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!resetb)
		wb_ack_i |=> !wb_ack_i)
		else $error("Wishbone ack held for more than one cycle");

	// A new head is loaded one cycle after a pop, so feedback never repeats back to back
	feedback_single_cycle: assert property (@(posedge clk) disable iff (!resetb)
		fb_valid_i |=> !fb_valid_i)
		else $error("Miss feedback high on two consecutive cycles");

	writeback_exclusive: assert property (@(posedge clk) disable iff (!resetb)
		!(reg_write_i && write_fb_i))
		else $error("Load and store writeback flags high together");

endmodule

bind mem_unit mem_unit_chk u_chk
(
	.clk         (clk),
	.resetb      (resetb),
	.wb_cyc_i    (wb_cyc_i),
	.wb_stb_i    (wb_stb_i),
	.wb_ack_i    (wb_ack_o),
	.fb_valid_i  (fb_valid_o),
	.reg_write_i (reg_write_o),
	.write_fb_i  (write_fb_valid_o)
);

`default_nettype wire

// ==== tests/mem_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_unit_tb;
	import gpu_mem_pkg::*;

	localparam int FB_W = MEM_AW + WARP_W + SCB_W;

	logic              clk;
	logic              resetb;
	mem_op_e           op_i;
	logic [MEM_AW-1:0] mem_addr_i;
	logic [LINE_W-1:0] write_data_i;
	logic [LANES-1:0]  lane_wmask_i;
	logic [WARP_W-1:0] warp_id_i;
	logic [SCB_W-1:0]  scb_id_i;
	logic [REG_W-1:0]  reg_addr_i;
	logic [LANES-1:0]  thread_mask_i;
	logic              hit_i;
	logic              addr_valid_i;
	logic [LAT_W-1:0]  miss_latency_i;
	logic              miss_wait_i;
	logic              reg_write_o;
	logic              write_fb_valid_o;
	logic [LINE_W-1:0] read_data_o;
	logic [WARP_W-1:0] warp_id_o;
	logic [SCB_W-1:0]  scb_id_o;
	logic [REG_W-1:0]  reg_addr_o;
	logic [LANES-1:0]  thread_mask_o;
	logic              fb_valid_o;
	logic [MEM_AW-1:0] fb_addr_o;
	logic [WARP_W-1:0] fb_warp_o;
	logic [SCB_W-1:0]  fb_scb_o;
	logic              mq_full_o;
	logic              wb_cyc_i;
	logic              wb_stb_i;
	logic              wb_we_i;
	logic [WB_AW-1:0]  wb_adr_i;
	logic [LANE_W-1:0] wb_dat_i;
	logic [LANE_W-1:0] wb_dat_o;
	logic              wb_ack_o;

	integer seed;
	int     errors;
	int     cyc;
	logic   run_chk;

	// Only 16 lines are used, indexed by the low four address bits
	logic [LINE_W-1:0] model [0:15];
	logic [FB_W-1:0]   fb_q [$];

	// Index 0 holds the operation driven last cycle, index 1 the one before
	mem_op_e           e_op    [0:1];
	logic [LINE_W-1:0] e_data  [0:1];
	logic [WARP_W-1:0] e_warp  [0:1];
	logic [SCB_W-1:0]  e_scb   [0:1];
	logic [REG_W-1:0]  e_reg   [0:1];
	logic [LANES-1:0]  e_tmask [0:1];
	logic [1:0]        e_valid;

	mem_unit uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
	end

	task automatic compare(input string name, input logic [LINE_W-1:0] got,
		input logic [LINE_W-1:0] exp);
		begin
			if (got !== exp)
			begin
				$display("MISMATCH %s got %h expected %h", name, got, exp);
				errors = errors + 1;
			end
		end
	endtask

	task automatic drive_op(input mem_op_e op, input logic [3:0] line,
		input logic [LANES-1:0] wmask, input logic miss, input logic [LAT_W-1:0] lat,
		input logic wt);
		logic [31:0]       r;
		logic [31:0]       r2;
		logic [LINE_W-1:0] wd;
		int                i;
		begin
			r = $random(seed);
			r2 = $random(seed);
			for (i = 0; i < LANES; i++)
			begin
				wd[i*LANE_W +: LANE_W] = $random(seed);
			end
			@(posedge clk);
			op_i           <= op;
			mem_addr_i     <= {r2[17:0], 5'd0, line};
			write_data_i   <= wd;
			lane_wmask_i   <= wmask;
			warp_id_i      <= r[2:0];
			scb_id_i       <= r[4:3];
			reg_addr_i     <= r[9:5];
			thread_mask_i  <= r[17:10];
			addr_valid_i   <= miss | r2[31];
			hit_i          <= !miss && (r2[31] || r2[30]);
			miss_latency_i <= lat;
			miss_wait_i    <= wt;
		end
	endtask

	task automatic drive_idle();
		begin
			drive_op(MOP_NONE, 4'd0, '0, 1'b0, '0, 1'b0);
		end
	endtask

	task automatic step_random();
		logic [31:0] r;
		mem_op_e     op;
		logic        miss;
		begin
			r = $random(seed);
			case (r[1:0])
				2'd0: op = MOP_NONE;
				2'd1: op = MOP_LOAD;
				default: op = MOP_STORE;
			endcase
			// One slot of margin covers the push still on its way into the queue
			miss = (r[4:2] == 3'd0) && (fb_q.size() < MQ_DEPTH - 1);
			drive_op(op, r[8:5], r[16:9], miss, r[21:17], r[24:22] == 3'd0);
		end
	endtask

	task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
		input logic [LANE_W-1:0] dat, output logic [LANE_W-1:0] rdat);
		int   n;
		logic seen;
		begin
			@(posedge clk);
			wb_cyc_i <= 1'b1;
			wb_stb_i <= 1'b1;
			wb_we_i  <= we;
			wb_adr_i <= adr;
			wb_dat_i <= dat;
			n = 0;
			seen = 1'b0;
			while (!seen && n < 8)
			begin
				@(negedge clk);
				n = n + 1;
				seen = wb_ack_o;
			end
			if (!seen)
			begin
				$display("Timeout: Wishbone ack never arrived for address %h", adr);
				errors = errors + 1;
			end
			else
			begin
				compare("wb_ack_o delay", n, 2);
			end
			rdat = wb_dat_o;
			@(posedge clk);
			wb_cyc_i <= 1'b0;
			wb_stb_i <= 1'b0;
			wb_we_i  <= 1'b0;
		end
	endtask

	task automatic drain();
		int n;
		begin
			n = 0;
			while (fb_q.size() != 0 && n < 600)
			begin
				@(posedge clk);
				n = n + 1;
			end
			if (fb_q.size() != 0)
			begin
				$display("Timeout: %0d misses never returned feedback", fb_q.size());
				errors = errors + 1;
				fb_q.delete();
			end
		end
	endtask

	task automatic wait_feedback(output logic seen);
		int n;
		begin
			n = 0;
			seen = 1'b0;
			while (!seen && n < 64)
			begin
				@(negedge clk);
				n = n + 1;
				seen = fb_valid_o;
			end
			if (!seen)
			begin
				$display("Timeout: no miss feedback within 64 cycles");
				errors = errors + 1;
			end
		end
	endtask

	task automatic lone_miss(input logic [LAT_W-1:0] lat, input logic wt);
		int   k;
		int   eff;
		logic seen;
		begin
			eff = (wt || lat == 0) ? 1 : lat;
			drain();
			drive_op(MOP_NONE, lat[3:0], '0, 1'b1, lat, wt);
			@(negedge clk);
			k = cyc;
			drive_idle();
			wait_feedback(seen);
			if (seen)
			begin
				compare("fb_valid_o cycle", cyc, k + 2 + eff);
			end
		end
	endtask

	task automatic fill_queue();
		logic seen;
		begin
			drain();
			repeat (MQ_DEPTH) drive_op(MOP_NONE, 4'd1, '0, 1'b1, 5'd31, 1'b0);
			drive_idle();
			@(negedge clk);
			compare("mq_full_o", mq_full_o, 1'b1);
			wait_feedback(seen);
			if (seen)
			begin
				compare("mq_full_o", mq_full_o, 1'b0);
			end
			drain();
		end
	endtask

	always @(negedge clk)
	begin : check_outputs
		int            i;
		logic [FB_W-1:0] fb_exp;
		if (!run_chk)
		begin
			e_valid = 2'b00;
		end
		else
		begin
			if (e_valid[1])
			begin
				compare("reg_write_o", reg_write_o, e_op[1] == MOP_LOAD);
				compare("write_fb_valid_o", write_fb_valid_o, e_op[1] == MOP_STORE);
				compare("read_data_o", read_data_o, e_data[1]);
				if (e_op[1] != MOP_NONE)
				begin
					compare("warp_id_o", warp_id_o, e_warp[1]);
					compare("scb_id_o", scb_id_o, e_scb[1]);
					compare("reg_addr_o", reg_addr_o, e_reg[1]);
					compare("thread_mask_o", thread_mask_o, e_tmask[1]);
				end
			end
			if (fb_valid_o)
			begin
				if (fb_q.size() == 0)
				begin
					$display("Miss feedback arrived while no miss was pending");
					errors = errors + 1;
				end
				else
				begin
					fb_exp = fb_q.pop_front();
					compare("fb_addr_o", fb_addr_o, fb_exp[FB_W-1:WARP_W+SCB_W]);
					compare("fb_warp_o", fb_warp_o, fb_exp[WARP_W+SCB_W-1:SCB_W]);
					compare("fb_scb_o", fb_scb_o, fb_exp[SCB_W-1:0]);
				end
			end
			// Here the model holds exactly the misses the queue still holds
			compare("mq_full_o", mq_full_o, fb_q.size() == MQ_DEPTH);
			e_op[1]    = e_op[0];
			e_data[1]  = e_data[0];
			e_warp[1]  = e_warp[0];
			e_scb[1]   = e_scb[0];
			e_reg[1]   = e_reg[0];
			e_tmask[1] = e_tmask[0];
			e_valid[1] = e_valid[0];
			e_op[0]    = op_i;
			e_warp[0]  = warp_id_i;
			e_scb[0]   = scb_id_i;
			e_reg[0]   = reg_addr_i;
			e_tmask[0] = thread_mask_i;
			e_valid[0] = 1'b1;
			e_data[0]  = '0;
			if (op_i == MOP_LOAD)
			begin
				e_data[0] = model[mem_addr_i[3:0]];
			end
			if (op_i == MOP_STORE)
			begin
				for (i = 0; i < LANES; i++)
				begin
					if (lane_wmask_i[i])
					begin
						model[mem_addr_i[3:0]][i*LANE_W +: LANE_W] =
							write_data_i[i*LANE_W +: LANE_W];
					end
				end
			end
			// Misses are only issued with room left, so the queue takes each on the next edge
			if (addr_valid_i && !hit_i)
			begin
				fb_q.push_back({mem_addr_i, warp_id_i, scb_id_i});
			end
		end
	end

	initial
	begin : main
		int                i;
		logic [31:0]       r;
		logic [WB_AW-1:0]  adr;
		logic [LANE_W-1:0] wd32;
		logic [LANE_W-1:0] rd32;
		seed = 58;
		errors = 0;
		cyc = 0;
		run_chk = 1'b0;
		e_valid = 2'b00;
		resetb = 1'b0;
		op_i = MOP_NONE;
		mem_addr_i = '0;
		write_data_i = '0;
		lane_wmask_i = '0;
		warp_id_i = '0;
		scb_id_i = '0;
		reg_addr_i = '0;
		thread_mask_i = '0;
		hit_i = 1'b1;
		addr_valid_i = 1'b0;
		miss_latency_i = '0;
		miss_wait_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		repeat (4) @(posedge clk);
		resetb <= 1'b1;
		@(negedge clk);
		compare("reg_write_o", reg_write_o, 1'b0);
		compare("write_fb_valid_o", write_fb_valid_o, 1'b0);
		compare("fb_valid_o", fb_valid_o, 1'b0);
		compare("wb_ack_o", wb_ack_o, 1'b0);
		compare("mq_full_o", mq_full_o, 1'b0);
		@(posedge clk);
		run_chk = 1'b1;
		for (i = 0; i < 16; i++)
		begin
			drive_op(MOP_STORE, i[3:0], '1, 1'b0, '0, 1'b0);
		end
		repeat (300) step_random();
		drive_idle();
		for (i = 0; i < 16; i++)
		begin
			r = $random(seed);
			adr = {5'd0, r[6:0]};
			wd32 = $random(seed);
			wb_access(1'b1, adr, wd32, rd32);
			model[adr[6:3]][adr[2:0]*LANE_W +: LANE_W] = wd32;
		end
		repeat (150) step_random();
		drive_idle();
		repeat (2) @(posedge clk);
		for (i = 0; i < 16; i++)
		begin
			r = $random(seed);
			adr = {5'd0, r[6:0]};
			wb_access(1'b0, adr, '0, rd32);
			compare("wb_dat_o", rd32, model[adr[6:3]][adr[2:0]*LANE_W +: LANE_W]);
		end
		lone_miss(5'd0, 1'b0);
		lone_miss(5'd9, 1'b1);
		for (i = 0; i < 6; i++)
		begin
			r = $random(seed);
			lone_miss(r[4:0], r[7:5] == 3'd0);
		end
		fill_queue();
		repeat (3) @(posedge clk);
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
logic/gpu_mem_pkg.sv
logic/lane_bank.sv
logic/miss_queue.sv
logic/fill_port.sv
logic/mem_stage.sv
logic/mem_unit.sv
tests/mem_unit_chk.sv
tests/mem_unit_tb.sv
